// File: hdl/sd_conv_pkg.sv
// Widths, digit codes and pipeline latencies shared by the converter RTL and its testbench
`default_nettype none

package sd_conv_pkg;

    // Word geometry
    localparam int SD_DIGITS = 8;
    localparam int SD_CODE_W = 2 * SD_DIGITS;
    localparam int SUM_W     = SD_DIGITS + 1;

    // Two-bit digit encoding, 10 never appears in a legal word
    localparam logic [1:0] DIGIT_ZERO = 2'b00;
    localparam logic [1:0] DIGIT_POS  = 2'b01;
    localparam logic [1:0] DIGIT_NEG  = 2'b11;
    localparam logic [1:0] DIGIT_BAD  = 2'b10;

    // Pipeline depths in register ranks
    localparam int PFX_LEVELS = $clog2(SUM_W);
    localparam int ADD_LAT    = PFX_LEVELS + 2;
    localparam int CONV_LAT   = ADD_LAT + 2;
    localparam int TOP_LAT    = CONV_LAT + 1;

endpackage

`default_nettype wire

// File: hdl/sd_digit_unpack.sv
// Input stage that registers a signed-digit word as separate positive and negative bit vectors
`default_nettype none
`timescale 1ns/1ps

module sd_digit_unpack import sd_conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [SD_CODE_W-1:0] sd_code,
    input  logic                 in_valid,
    output logic [SD_DIGITS-1:0] pos,
    output logic [SD_DIGITS-1:0] neg,
    output logic                 unp_valid,
    output logic                 unp_err
);

    logic [SD_DIGITS-1:0] pos_d;
    logic [SD_DIGITS-1:0] neg_d;
    logic [SD_DIGITS-1:0] bad_d;

    // One bit per digit, an illegal code lands in neither vector
    always_comb begin
        pos_d = '0;
        neg_d = '0;
        bad_d = '0;
        for (int i = 0; i < SD_DIGITS; i++) begin
            case (sd_code[2*i +: 2])
                DIGIT_ZERO: ;
                DIGIT_POS:  pos_d[i] = 1'b1;
                DIGIT_NEG:  neg_d[i] = 1'b1;
                DIGIT_BAD:  bad_d[i] = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos       <= '0;
            neg       <= '0;
            unp_valid <= 1'b0;
            unp_err   <= 1'b0;
        end else begin
            unp_valid <= in_valid;
            unp_err   <= in_valid & (|bad_d);
            // Vectors hold their last word between strobes
            if (in_valid) begin
                pos <= pos_d;
                neg <= neg_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/prefix_adder.sv
// Pipelined Han-Carlson adder with carry-in, one register rank per prefix level, any width
`default_nettype none
`timescale 1ns/1ps

module prefix_adder #(
    parameter int width = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum
);

    // Only the low width-1 positions produce a carry that is used
    localparam int pw     = width - 1;
    localparam int levels = $clog2(pw) + 1;

    logic [width-1:0] p_in;
    logic [pw-1:0]    g_in;

    // Group generate/propagate per level, original propagate and cin ride alongside
    logic [pw-1:0]    g_lvl [levels];
    logic [pw-1:0]    p_lvl [levels];
    logic [width-1:0] p_dly [levels];
    logic             cin_dly [levels];

    logic [pw-1:0]    g_fix;
    logic [width-1:0] carry_q;
    logic [width-1:0] p_fin;
    logic [width-1:0] sum_q;

    assign p_in = a ^ b;

    // Carry-in enters as an extra generate at bit 0
    always_comb begin
        g_in    = a[pw-1:0] & b[pw-1:0];
        g_in[0] = g_in[0] | (p_in[0] & cin);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            g_lvl[0]   <= '0;
            p_lvl[0]   <= '0;
            p_dly[0]   <= '0;
            cin_dly[0] <= 1'b0;
        end else begin
            g_lvl[0]   <= g_in;
            p_lvl[0]   <= p_in[pw-1:0];
            p_dly[0]   <= p_in;
            cin_dly[0] <= cin;
        end
    end

    // Odd positions, Kogge-Stone style at distance 1, 2, 4 ...
    for (genvar l = 0; l < levels - 1; l++) begin : g_odd_level
        logic [pw-1:0] g_nxt;
        logic [pw-1:0] p_nxt;

        for (genvar i = 0; i < pw; i++) begin : g_cell
            if ((i % 2 == 1) && (i >= (1 << l))) begin : g_black
                assign g_nxt[i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][i - (1 << l)]);
                assign p_nxt[i] = p_lvl[l][i] & p_lvl[l][i - (1 << l)];
            end else begin : g_pass
                assign g_nxt[i] = g_lvl[l][i];
                assign p_nxt[i] = p_lvl[l][i];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                g_lvl[l+1]   <= '0;
                p_lvl[l+1]   <= '0;
                p_dly[l+1]   <= '0;
                cin_dly[l+1] <= 1'b0;
            end else begin
                g_lvl[l+1]   <= g_nxt;
                p_lvl[l+1]   <= p_nxt;
                p_dly[l+1]   <= p_dly[l];
                cin_dly[l+1] <= cin_dly[l];
            end
        end
    end

    // Even positions pick up the finished prefix of their odd neighbour
    for (genvar i = 0; i < pw; i++) begin : g_fixup
        if ((i % 2 == 0) && (i >= 2)) begin : g_grey
            assign g_fix[i] = g_lvl[levels-1][i] |
                              (p_lvl[levels-1][i] & g_lvl[levels-1][i-1]);
        end else begin : g_pass
            assign g_fix[i] = g_lvl[levels-1][i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_q <= '0;
            p_fin   <= '0;
        end else begin
            carry_q <= {g_fix, cin_dly[levels-1]};
            p_fin   <= p_dly[levels-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else begin
            sum_q <= p_fin ^ carry_q;
        end
    end

    assign sum = sum_q;

endmodule

`default_nettype wire

// File: hdl/sd_to_twos.sv
// Conversion stage forming pos minus neg in two's complement, with valid and error kept in step
`default_nettype none
`timescale 1ns/1ps

module sd_to_twos import sd_conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [SD_DIGITS-1:0] pos,
    input  logic [SD_DIGITS-1:0] neg,
    input  logic                 unp_valid,
    input  logic                 unp_err,
    output logic [SUM_W-1:0]     twos,
    output logic                 out_valid,
    output logic                 err
);

    logic [SUM_W-1:0]    a_q;
    logic [SUM_W-1:0]    b_q;
    logic [SUM_W-1:0]    sum;
    logic [CONV_LAT-1:0] vld_sr;
    logic [CONV_LAT-1:0] err_sr;

    // pos + ~neg + 1 in the extended width is pos - neg
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= {{(SUM_W - SD_DIGITS){1'b0}}, pos};
            b_q <= ~{{(SUM_W - SD_DIGITS){1'b0}}, neg};
        end
    end

    prefix_adder #(
        .width (SUM_W)
    ) adder_i (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a_q),
        .b     (b_q),
        .cin   (1'b1),
        .sum   (sum)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
            err_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[CONV_LAT-2:0], unp_valid};
            err_sr <= {err_sr[CONV_LAT-2:0], unp_err};
        end
    end

    // Result only moves when a word arrives, idle cycles leave twos alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            twos <= '0;
        end else if (vld_sr[CONV_LAT-2]) begin
            twos <= sum;
        end
    end

    assign out_valid = vld_sr[CONV_LAT-1];
    assign err       = err_sr[CONV_LAT-1];

endmodule

`default_nettype wire

// File: hdl/sd_conv_top.sv
// Top level of the signed-digit to two's-complement converter, unpacker followed by adder stage
`default_nettype none
`timescale 1ns/1ps

module sd_conv_top import sd_conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [SD_CODE_W-1:0] sd_code,
    input  logic                 in_valid,
    output logic [SUM_W-1:0]     twos,
    output logic                 out_valid,
    output logic                 err
);

    logic [SD_DIGITS-1:0] pos;
    logic [SD_DIGITS-1:0] neg;
    logic                 unp_valid;
    logic                 unp_err;

    sd_digit_unpack unpack_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sd_code   (sd_code),
        .in_valid  (in_valid),
        .pos       (pos),
        .neg       (neg),
        .unp_valid (unp_valid),
        .unp_err   (unp_err)
    );

    sd_to_twos conv_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pos       (pos),
        .neg       (neg),
        .unp_valid (unp_valid),
        .unp_err   (unp_err),
        .twos      (twos),
        .out_valid (out_valid),
        .err       (err)
    );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// Testbench clock and reset source, free-running clock with reset held low for the first cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the flops
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/sd_conv_checker.sv
// Testbench monitor that checks converter outputs against expectations queued by the testbench top
`default_nettype none
`timescale 1ns/1ps

module sd_conv_checker import sd_conv_pkg::*; #(
    parameter int clk_period = 40
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [SUM_W-1:0] twos,
    input  logic             out_valid,
    input  logic             err
);

    logic [SUM_W-1:0] exp_twos_q [$];
    logic             exp_err_q [$];
    time              stamp_q [$];
    int               pushed       = 0;
    int               value_errs   = 0;
    int               order_errs   = 0;
    int               latency_errs = 0;

    task automatic push_expect(input logic [SUM_W-1:0] exp_twos, input logic exp_err);
        exp_twos_q.push_back(exp_twos);
        exp_err_q.push_back(exp_err);
        stamp_q.push_back($time);
        pushed++;
    endtask

    function automatic int pending();
        return exp_twos_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [SUM_W-1:0] exp_val,
                                 input logic [SUM_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAIL %s: expected 0x%h, got 0x%h at %0t", name, exp_val, act_val, $time);
            value_errs++;
        end
    endtask

    task automatic check_result();
        logic [SUM_W-1:0] exp_twos;
        logic             exp_err;
        time              waited;
        if (exp_twos_q.size() == 0) begin
            $display("Unexpected result at %0t: out_valid is high with no word in flight", $time);
            order_errs++;
        end else begin
            exp_twos = exp_twos_q.pop_front();
            exp_err  = exp_err_q.pop_front();
            waited   = $time - stamp_q.pop_front();
            compare_field("twos", exp_twos, twos);
            compare_field("err", {{(SUM_W-1){1'b0}}, exp_err}, {{(SUM_W-1){1'b0}}, err});
            // Driven on a falling edge and seen on a falling edge, so whole periods apart
            if (waited != time'(TOP_LAT * clk_period)) begin
                $display("Latency wrong: result came %0d ns after its word, %0d cycles expected",
                         waited, TOP_LAT);
                latency_errs++;
            end
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling edge
    always @(negedge clk) begin
        if (!rst_n || pushed == 0) begin
            compare_field("twos", '0, twos);
            compare_field("out_valid", '0, {{(SUM_W-1){1'b0}}, out_valid});
            compare_field("err", '0, {{(SUM_W-1){1'b0}}, err});
        end else if (out_valid === 1'b1) begin
            check_result();
        end
    end

    task automatic check_drained();
        if (exp_twos_q.size() != 0) begin
            $display("%0d expected results never came out of the DUT", exp_twos_q.size());
            order_errs += exp_twos_q.size();
        end
    endtask

    task automatic report_summary(output int total);
        total = value_errs + order_errs + latency_errs;
        $display("Checked %0d words: %0d value, %0d order, %0d latency errors, %0d in total",
                 pushed, value_errs, order_errs, latency_errs, total);
    endtask

endmodule

`default_nettype wire

// File: test/sd_conv_tb.sv
// Testbench top that replays the trace file into the converter and hands expectations to the checker
`default_nettype none
`timescale 1ns/1ps

module sd_conv_tb import sd_conv_pkg::*; ();

    localparam int    clk_period = 40;
    localparam string trace_path = "test/sd_conv_trace.txt";

    logic                 clk;
    logic                 rst_n;
    logic [SD_CODE_W-1:0] sd_code;
    logic                 in_valid;
    logic [SUM_W-1:0]     twos;
    logic                 out_valid;
    logic                 err;

    // One entry per trace line
    logic [SD_CODE_W-1:0] code_q [$];
    logic                 vld_q [$];
    logic [SUM_W-1:0]     res_q [$];
    logic                 bad_q [$];
    logic                 loaded = 1'b0;

    tb_clock #(
        .period       (clk_period),
        .reset_cycles (3)
    ) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sd_conv_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sd_code   (sd_code),
        .in_valid  (in_valid),
        .twos      (twos),
        .out_valid (out_valid),
        .err       (err)
    );

    sd_conv_checker #(
        .clk_period (clk_period)
    ) chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .twos      (twos),
        .out_valid (out_valid),
        .err       (err)
    );

    task automatic load_trace(output bit ok);
        int                   fd;
        int                   n;
        string                line;
        logic [SD_CODE_W-1:0] code;
        logic                 vld;
        logic [SUM_W-1:0]     res;
        logic                 bad;
        fd = $fopen(trace_path, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %b %h %b", code, vld, res, bad);
                    if (n == 4) begin
                        code_q.push_back(code);
                        vld_q.push_back(vld);
                        res_q.push_back(res);
                        bad_q.push_back(bad);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && (code_q.size() != 0);
    endtask

    initial begin : stimulus
        bit ok;
        int total;
        sd_code  = '0;
        in_valid = 1'b0;
        load_trace(ok);
        if (!ok) begin
            $display("Could not read any words from the trace file %s", trace_path);
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (rst_n === 1'b1);
            foreach (code_q[i]) begin
                @(negedge clk);
                sd_code  = code_q[i];
                in_valid = vld_q[i];
                if (vld_q[i]) begin
                    chk_i.push_expect(res_q[i], bad_q[i]);
                end
            end
            @(negedge clk);
            sd_code  = '0;
            in_valid = 1'b0;
            while (chk_i.pending() != 0) begin
                @(negedge clk);
            end
            // A few idle cycles catch a stray out_valid
            repeat (3) @(negedge clk);
            chk_i.check_drained();
            chk_i.report_summary(total);
            if (total == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int total;
        wait (loaded === 1'b1);
        #((code_q.size() + TOP_LAT + 20) * clk_period);
        $display("Timeout: the trace did not complete within %0d cycles",
                 code_q.size() + TOP_LAT + 20);
        chk_i.report_summary(total);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/sd_conv_trace.txt
# Columns: signed-digit code (hex, 2 bits per digit), valid, expected twos (hex), expected err
# Digit codes 00 = 0, 01 = +1, 11 = -1, 10 = illegal; idle lines keep valid at 0
0000 0 000 0
0000 1 000 0
0001 1 001 0
5555 1 0FF 0
FFFF 1 101 0
7FFF 1 001 0
4000 1 080 0
C000 1 180 0
0003 1 1FF 0
0007 1 001 0
D555 1 1FF 0
0002 1 000 1
8001 1 001 1
0000 0 000 0
1234 1 03E 1
3C3C 1 19A 0
5F5F 1 099 0
F5F5 1 167 0
0000 0 000 0
FFFF 0 000 0
0DFF 1 1E1 0
AAAA 1 000 1
1555 1 07F 0
7F7F 1 011 0
0040 1 008 0
0100 1 010 0
C001 1 181 0
0000 0 000 0
0000 0 000 0
4003 1 07F 0
3FFF 1 181 0
0600 1 020 1
0000 1 000 0

// File: tb.f
hdl/sd_conv_pkg.sv
hdl/sd_digit_unpack.sv
hdl/prefix_adder.sv
hdl/sd_to_twos.sv
hdl/sd_conv_top.sv
test/tb_clock.sv
test/sd_conv_checker.sv
test/sd_conv_tb.sv

// File: Makefile
# Verilator build and run of the signed-digit converter testbench
VERILATOR := verilator
TOP       := sd_conv_tb
FILELIST  := tb.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
